/* common/la_decode_pkg.sv */
package la_decode_pkg;

    // Major opcode and function fields in one group per instruction format
    localparam logic [16:0] OP_ADD_W  = 17'h00020;   // 3R at ir[31:15]
    localparam logic [16:0] OP_SUB_W  = 17'h00022;
    localparam logic [16:0] OP_SLT    = 17'h00024;
    localparam logic [16:0] OP_SLTU   = 17'h00025;
    localparam logic [16:0] OP_NOR    = 17'h00028;
    localparam logic [16:0] OP_AND    = 17'h00029;
    localparam logic [16:0] OP_OR     = 17'h0002a;
    localparam logic [16:0] OP_XOR    = 17'h0002b;
    localparam logic [16:0] OP_SLL_W  = 17'h0002e;
    localparam logic [16:0] OP_SRL_W  = 17'h0002f;
    localparam logic [16:0] OP_SRA_W  = 17'h00030;
    localparam logic [16:0] OP_BREAK  = 17'h00054;
    localparam logic [16:0] OP_SYSCALL = 17'h00056;
    localparam logic [16:0] OP_SLLI_W = 17'h00081;   // 2R + ui5
    localparam logic [16:0] OP_SRLI_W = 17'h00089;
    localparam logic [16:0] OP_SRAI_W = 17'h00091;

    localparam logic [9:0] OP_SLTI   = 10'h008;      // 2R + si12 at ir[31:22]
    localparam logic [9:0] OP_SLTUI  = 10'h009;
    localparam logic [9:0] OP_ADDI_W = 10'h00a;
    localparam logic [9:0] OP_ANDI   = 10'h00d;
    localparam logic [9:0] OP_ORI    = 10'h00e;
    localparam logic [9:0] OP_XORI   = 10'h00f;
    localparam logic [9:0] OP_LD_B   = 10'h0a0;
    localparam logic [9:0] OP_LD_H   = 10'h0a1;
    localparam logic [9:0] OP_LD_W   = 10'h0a2;
    localparam logic [9:0] OP_ST_B   = 10'h0a4;
    localparam logic [9:0] OP_ST_H   = 10'h0a5;
    localparam logic [9:0] OP_ST_W   = 10'h0a6;
    localparam logic [9:0] OP_LD_BU  = 10'h0a8;
    localparam logic [9:0] OP_LD_HU  = 10'h0a9;

    localparam logic [6:0] OP_LU12I_W    = 7'h0a;   // 1R + si20 at ir[31:25]
    localparam logic [6:0] OP_PCADDU12I  = 7'h0e;

    localparam logic [5:0] OP_JIRL = 6'h13;          // ir[31:26]
    localparam logic [5:0] OP_B    = 6'h14;
    localparam logic [5:0] OP_BL   = 6'h15;
    localparam logic [5:0] OP_BEQ  = 6'h16;
    localparam logic [5:0] OP_BNE  = 6'h17;
    localparam logic [5:0] OP_BLT  = 6'h18;
    localparam logic [5:0] OP_BGE  = 6'h19;
    localparam logic [5:0] OP_BLTU = 6'h1a;
    localparam logic [5:0] OP_BGEU = 6'h1b;

    localparam logic [5:0] ECODE_ADE = 6'd8;
    localparam logic [5:0] ECODE_SYS = 6'd11;
    localparam logic [5:0] ECODE_BRK = 6'd12;
    localparam logic [5:0] ECODE_INE = 6'd13;
    localparam logic       ESUB_ADEM = 1'b1;

    // sub_op codes whose meaning depends on the unit class
    localparam logic [2:0] SUB_B     = 3'd0;
    localparam logic [2:0] SUB_BEQ   = 3'd1;
    localparam logic [2:0] SUB_BNE   = 3'd2;
    localparam logic [2:0] SUB_BLT   = 3'd3;
    localparam logic [2:0] SUB_BGE   = 3'd4;
    localparam logic [2:0] SUB_BLTU  = 3'd5;
    localparam logic [2:0] SUB_BGEU  = 3'd6;
    localparam logic [2:0] SUB_LD_B  = 3'd0;
    localparam logic [2:0] SUB_LD_H  = 3'd1;
    localparam logic [2:0] SUB_LD_W  = 3'd2;
    localparam logic [2:0] SUB_ST_B  = 3'd3;
    localparam logic [2:0] SUB_ST_H  = 3'd4;
    localparam logic [2:0] SUB_ST_W  = 3'd5;
    localparam logic [2:0] SUB_LD_BU = 3'd6;
    localparam logic [2:0] SUB_LD_HU = 3'd7;
    localparam logic [2:0] SUB_JIRL  = 3'd0;
    localparam logic [2:0] SUB_BL    = 3'd1;

    typedef enum logic [2:0] {
        UNIT_ALU, UNIT_BRANCH, UNIT_LINK, UNIT_MEM, UNIT_EXCP
    } unit_e;

    typedef enum logic [3:0] {
        ALU_AND = 4'd0, ALU_OR = 4'd1, ALU_NOR = 4'd2, ALU_XOR = 4'd3,
        ALU_ADD = 4'd4, ALU_SUB = 4'd5, ALU_SLL = 4'd6, ALU_SRL = 4'd7,
        ALU_SRA = 4'd8, ALU_SLT = 4'd9, ALU_SLTU = 4'd10, ALU_PASS_B = 4'd12
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC2_REG = 2'd0, SRC2_IMM = 2'd1, SRC2_CMP_REG = 2'd2, SRC2_FOUR = 2'd3
    } src2_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_UI5, IMM_SI12, IMM_UI12, IMM_SI20_HI, IMM_OFFS16, IMM_OFFS26
    } imm_fmt_e;

    typedef union packed {
        struct packed { logic [16:0] op; logic [4:0] rk;  logic [4:0] rj; logic [4:0] rd; } r3;
        struct packed { logic [16:0] op; logic [4:0] ui5; logic [4:0] rj; logic [4:0] rd; } r2i5;
        struct packed { logic [9:0] op; logic [11:0] i12; logic [4:0] rj; logic [4:0] rd; } r2i12;
        struct packed { logic [5:0] op; logic [15:0] i16; logic [4:0] rj; logic [4:0] rd; } r2i16;
        struct packed { logic [6:0] op; logic [19:0] i20; logic [4:0] rd; } r1i20;
        struct packed { logic [5:0] op; logic [15:0] offs_lo; logic [9:0] offs_hi; } i26;
    } inst_u;

    typedef struct packed {
        unit_e      unit;
        alu_op_e    alu_op;
        logic [2:0] sub_op;
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        logic       pc_branch;
        logic       src1_pc;
        src2_e      src2;
    } decode_ctrl_t;

    typedef struct packed {
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [4:0]  rd;
        logic [31:0] imm;
    } operands_t;

    typedef struct packed {
        logic [5:0] ecode;
        logic       esub;
    } excp_t;

endpackage

/* hw/decoder/excp_resolve.sv */
`timescale 1ns/100ps

module excp_resolve (
    input  la_decode_pkg::decode_ctrl_t dec_ctrl,
    input  la_decode_pkg::operands_t    dec_ops,
    input  la_decode_pkg::excp_t        sw_excp,
    input  logic [31:0]                 pc,
    input  logic [1:0]                  plv,
    output la_decode_pkg::decode_ctrl_t ctrl,
    output la_decode_pkg::operands_t    ops,
    output la_decode_pkg::excp_t        excp
);

    logic adef;
    logic adem;

    assign adef = |pc[1:0];                      // Misaligned fetch
    assign adem = pc[31] && (plv != 2'd0);       // Upper half needs PLV0

    always_comb
    begin
        ctrl = dec_ctrl;
        ops  = dec_ops;
        excp = sw_excp;
        if (adef || adem)
        begin
            ctrl       = '0;
            ctrl.unit  = la_decode_pkg::UNIT_EXCP;
            ops        = '0;
            excp.ecode = la_decode_pkg::ECODE_ADE;
            excp.esub  = adef ? 1'b0 : la_decode_pkg::ESUB_ADEM;   // ADEF has priority
        end
    end

endmodule

/* hw/decoder/opcode_decode.sv */
`timescale 1ns/100ps

module opcode_decode (
    input  la_decode_pkg::inst_u        ir,
    output la_decode_pkg::decode_ctrl_t ctrl,
    output la_decode_pkg::imm_fmt_e     imm_fmt,
    output la_decode_pkg::excp_t        sw_excp
);

    function automatic la_decode_pkg::decode_ctrl_t alu_ctrl(
        input la_decode_pkg::alu_op_e op,
        input logic                   use_imm
    );
        la_decode_pkg::decode_ctrl_t c;
        c           = '0;
        c.unit      = la_decode_pkg::UNIT_ALU;
        c.alu_op    = op;
        c.reg_write = 1'b1;
        c.src2      = use_imm ? la_decode_pkg::SRC2_IMM : la_decode_pkg::SRC2_REG;
        return c;
    endfunction

    function automatic la_decode_pkg::decode_ctrl_t mem_ctrl(
        input logic [2:0] size,
        input logic       load
    );
        la_decode_pkg::decode_ctrl_t c;
        c           = '0;
        c.unit      = la_decode_pkg::UNIT_MEM;
        c.sub_op    = size;
        c.reg_write = load;
        c.mem_read  = load;
        c.mem_write = !load;
        return c;
    endfunction

    function automatic la_decode_pkg::decode_ctrl_t br_ctrl(
        input la_decode_pkg::alu_op_e op,
        input logic [2:0]             cond
    );
        la_decode_pkg::decode_ctrl_t c;
        c           = '0;
        c.unit      = la_decode_pkg::UNIT_BRANCH;
        c.alu_op    = op;                         // Compare op for the condition
        c.sub_op    = cond;
        c.pc_branch = 1'b1;
        c.src2      = la_decode_pkg::SRC2_CMP_REG;
        return c;
    endfunction

    function automatic la_decode_pkg::decode_ctrl_t link_ctrl(input logic [2:0] kind);
        la_decode_pkg::decode_ctrl_t c;
        c           = '0;
        c.unit      = la_decode_pkg::UNIT_LINK;
        c.alu_op    = la_decode_pkg::ALU_ADD;     // Link value is pc + 4
        c.sub_op    = kind;
        c.reg_write = 1'b1;
        c.pc_branch = 1'b1;
        c.src1_pc   = 1'b1;
        c.src2      = la_decode_pkg::SRC2_FOUR;
        return c;
    endfunction

    always_comb
    begin
        ctrl          = '0;
        ctrl.unit     = la_decode_pkg::UNIT_EXCP;  // Undecoded words fall to INE
        imm_fmt       = la_decode_pkg::IMM_NONE;
        sw_excp.ecode = la_decode_pkg::ECODE_INE;
        sw_excp.esub  = 1'b0;

        case (ir.r3.op)
            la_decode_pkg::OP_ADD_W:   ctrl = alu_ctrl(la_decode_pkg::ALU_ADD, 1'b0);
            la_decode_pkg::OP_SUB_W:   ctrl = alu_ctrl(la_decode_pkg::ALU_SUB, 1'b0);
            la_decode_pkg::OP_SLT:     ctrl = alu_ctrl(la_decode_pkg::ALU_SLT, 1'b0);
            la_decode_pkg::OP_SLTU:    ctrl = alu_ctrl(la_decode_pkg::ALU_SLTU, 1'b0);
            la_decode_pkg::OP_NOR:     ctrl = alu_ctrl(la_decode_pkg::ALU_NOR, 1'b0);
            la_decode_pkg::OP_AND:     ctrl = alu_ctrl(la_decode_pkg::ALU_AND, 1'b0);
            la_decode_pkg::OP_OR:      ctrl = alu_ctrl(la_decode_pkg::ALU_OR, 1'b0);
            la_decode_pkg::OP_XOR:     ctrl = alu_ctrl(la_decode_pkg::ALU_XOR, 1'b0);
            la_decode_pkg::OP_SLL_W:   ctrl = alu_ctrl(la_decode_pkg::ALU_SLL, 1'b0);
            la_decode_pkg::OP_SRL_W:   ctrl = alu_ctrl(la_decode_pkg::ALU_SRL, 1'b0);
            la_decode_pkg::OP_SRA_W:   ctrl = alu_ctrl(la_decode_pkg::ALU_SRA, 1'b0);
            la_decode_pkg::OP_SYSCALL: sw_excp.ecode = la_decode_pkg::ECODE_SYS;
            la_decode_pkg::OP_BREAK:   sw_excp.ecode = la_decode_pkg::ECODE_BRK;
            la_decode_pkg::OP_SLLI_W:  ctrl = alu_ctrl(la_decode_pkg::ALU_SLL, 1'b1);
            la_decode_pkg::OP_SRLI_W:  ctrl = alu_ctrl(la_decode_pkg::ALU_SRL, 1'b1);
            la_decode_pkg::OP_SRAI_W:  ctrl = alu_ctrl(la_decode_pkg::ALU_SRA, 1'b1);
            default: ;
        endcase
        if (ir.r3.op inside {la_decode_pkg::OP_SLLI_W, la_decode_pkg::OP_SRLI_W,
                             la_decode_pkg::OP_SRAI_W})
            imm_fmt = la_decode_pkg::IMM_UI5;

        case (ir.r2i12.op)
            la_decode_pkg::OP_SLTI:   ctrl = alu_ctrl(la_decode_pkg::ALU_SLT, 1'b1);
            la_decode_pkg::OP_SLTUI:  ctrl = alu_ctrl(la_decode_pkg::ALU_SLTU, 1'b1);
            la_decode_pkg::OP_ADDI_W: ctrl = alu_ctrl(la_decode_pkg::ALU_ADD, 1'b1);
            la_decode_pkg::OP_ANDI:   ctrl = alu_ctrl(la_decode_pkg::ALU_AND, 1'b1);
            la_decode_pkg::OP_ORI:    ctrl = alu_ctrl(la_decode_pkg::ALU_OR, 1'b1);
            la_decode_pkg::OP_XORI:   ctrl = alu_ctrl(la_decode_pkg::ALU_XOR, 1'b1);
            la_decode_pkg::OP_LD_B:   ctrl = mem_ctrl(la_decode_pkg::SUB_LD_B, 1'b1);
            la_decode_pkg::OP_LD_H:   ctrl = mem_ctrl(la_decode_pkg::SUB_LD_H, 1'b1);
            la_decode_pkg::OP_LD_W:   ctrl = mem_ctrl(la_decode_pkg::SUB_LD_W, 1'b1);
            la_decode_pkg::OP_ST_B:   ctrl = mem_ctrl(la_decode_pkg::SUB_ST_B, 1'b0);
            la_decode_pkg::OP_ST_H:   ctrl = mem_ctrl(la_decode_pkg::SUB_ST_H, 1'b0);
            la_decode_pkg::OP_ST_W:   ctrl = mem_ctrl(la_decode_pkg::SUB_ST_W, 1'b0);
            la_decode_pkg::OP_LD_BU:  ctrl = mem_ctrl(la_decode_pkg::SUB_LD_BU, 1'b1);
            la_decode_pkg::OP_LD_HU:  ctrl = mem_ctrl(la_decode_pkg::SUB_LD_HU, 1'b1);
            default: ;
        endcase
        if (ir.r2i12.op inside {la_decode_pkg::OP_ANDI, la_decode_pkg::OP_ORI,
                                la_decode_pkg::OP_XORI})
            imm_fmt = la_decode_pkg::IMM_UI12;          // Logic ops zero-extend
        else if (ctrl.unit == la_decode_pkg::UNIT_MEM || ir.r2i12.op inside
                 {la_decode_pkg::OP_SLTI, la_decode_pkg::OP_SLTUI, la_decode_pkg::OP_ADDI_W})
            imm_fmt = la_decode_pkg::IMM_SI12;

        if (ir.r1i20.op == la_decode_pkg::OP_LU12I_W)
        begin
            ctrl    = alu_ctrl(la_decode_pkg::ALU_PASS_B, 1'b1);
            imm_fmt = la_decode_pkg::IMM_SI20_HI;
        end
        if (ir.r1i20.op == la_decode_pkg::OP_PCADDU12I)
        begin
            ctrl         = alu_ctrl(la_decode_pkg::ALU_ADD, 1'b1);
            ctrl.src1_pc = 1'b1;
            imm_fmt      = la_decode_pkg::IMM_SI20_HI;
        end

        case (ir.i26.op)
            la_decode_pkg::OP_JIRL: ctrl = link_ctrl(la_decode_pkg::SUB_JIRL);
            la_decode_pkg::OP_BL:   ctrl = link_ctrl(la_decode_pkg::SUB_BL);
            la_decode_pkg::OP_B:    ctrl = br_ctrl(la_decode_pkg::ALU_AND, la_decode_pkg::SUB_B);
            la_decode_pkg::OP_BEQ:  ctrl = br_ctrl(la_decode_pkg::ALU_SUB, la_decode_pkg::SUB_BEQ);
            la_decode_pkg::OP_BNE:  ctrl = br_ctrl(la_decode_pkg::ALU_SUB, la_decode_pkg::SUB_BNE);
            la_decode_pkg::OP_BLT:  ctrl = br_ctrl(la_decode_pkg::ALU_SLT, la_decode_pkg::SUB_BLT);
            la_decode_pkg::OP_BGE:  ctrl = br_ctrl(la_decode_pkg::ALU_SLT, la_decode_pkg::SUB_BGE);
            la_decode_pkg::OP_BLTU: ctrl = br_ctrl(la_decode_pkg::ALU_SLTU, la_decode_pkg::SUB_BLTU);
            la_decode_pkg::OP_BGEU: ctrl = br_ctrl(la_decode_pkg::ALU_SLTU, la_decode_pkg::SUB_BGEU);
            default: ;
        endcase
        if (ir.i26.op == la_decode_pkg::OP_B || ir.i26.op == la_decode_pkg::OP_BL)
            imm_fmt = la_decode_pkg::IMM_OFFS26;
        else if (ctrl.pc_branch)
            imm_fmt = la_decode_pkg::IMM_OFFS16;         // JIRL and conditional branches

        if (ctrl.unit != la_decode_pkg::UNIT_EXCP)
            sw_excp = '0;
    end

endmodule

/* hw/decoder/operand_extract.sv */
`timescale 1ns/100ps

module operand_extract (
    input  la_decode_pkg::inst_u     ir,
    input  la_decode_pkg::imm_fmt_e  imm_fmt,
    output la_decode_pkg::operands_t ops
);

    logic is_reg3;
    logic is_bl;

    // 3R words carry no immediate but use all three register fields
    assign is_reg3 = ir.r3.op inside {
        la_decode_pkg::OP_ADD_W, la_decode_pkg::OP_SUB_W, la_decode_pkg::OP_SLT,
        la_decode_pkg::OP_SLTU, la_decode_pkg::OP_NOR, la_decode_pkg::OP_AND,
        la_decode_pkg::OP_OR, la_decode_pkg::OP_XOR, la_decode_pkg::OP_SLL_W,
        la_decode_pkg::OP_SRL_W, la_decode_pkg::OP_SRA_W};
    assign is_bl = (ir.i26.op == la_decode_pkg::OP_BL);

    always_comb
    begin
        ops = '0;
        case (imm_fmt)
            la_decode_pkg::IMM_NONE:
                if (is_reg3)
                begin
                    ops.rk = ir.r3.rk;
                    ops.rj = ir.r3.rj;
                    ops.rd = ir.r3.rd;
                end
            la_decode_pkg::IMM_UI5:
            begin
                ops.rj  = ir.r2i5.rj;
                ops.rd  = ir.r2i5.rd;
                ops.imm = {27'd0, ir.r2i5.ui5};
            end
            la_decode_pkg::IMM_SI12, la_decode_pkg::IMM_UI12:
            begin
                ops.rj  = ir.r2i12.rj;
                ops.rd  = ir.r2i12.rd;
                ops.imm = {{20{ir.r2i12.i12[11] && imm_fmt == la_decode_pkg::IMM_SI12}},
                           ir.r2i12.i12};
            end
            la_decode_pkg::IMM_SI20_HI:
            begin
                ops.rd  = ir.r1i20.rd;
                ops.imm = {ir.r1i20.i20, 12'd0};
            end
            la_decode_pkg::IMM_OFFS16:
            begin
                ops.rj  = ir.r2i16.rj;
                ops.rd  = ir.r2i16.rd;
                ops.imm = {{14{ir.r2i16.i16[15]}}, ir.r2i16.i16, 2'b00};
            end
            la_decode_pkg::IMM_OFFS26:
            begin
                ops.rd  = is_bl ? 5'd1 : 5'd0;          // BL links into r1
                ops.imm = {{4{ir.i26.offs_hi[9]}}, ir.i26.offs_hi, ir.i26.offs_lo, 2'b00};
            end
            default: ;
        endcase
    end

endmodule

/* hw/id_stage.sv */
`timescale 1ns/100ps

module id_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  la_decode_pkg::inst_u        ir,
    input  logic [31:0]                 pc,
    input  logic [1:0]                  plv,
    output logic                        out_valid,
    output la_decode_pkg::decode_ctrl_t ctrl,
    output la_decode_pkg::operands_t    ops,
    output la_decode_pkg::excp_t        excp
);

    la_decode_pkg::decode_ctrl_t dec_ctrl;
    la_decode_pkg::imm_fmt_e     imm_fmt;
    la_decode_pkg::excp_t        sw_excp;
    la_decode_pkg::operands_t    dec_ops;
    la_decode_pkg::decode_ctrl_t fin_ctrl;
    la_decode_pkg::operands_t    fin_ops;
    la_decode_pkg::excp_t        fin_excp;

    opcode_decode i_opcode_decode (
        .ir      (ir),
        .ctrl    (dec_ctrl),
        .imm_fmt (imm_fmt),
        .sw_excp (sw_excp)
    );

    operand_extract i_operand_extract (
        .ir      (ir),
        .imm_fmt (imm_fmt),
        .ops     (dec_ops)
    );

    excp_resolve i_excp_resolve (
        .dec_ctrl (dec_ctrl),
        .dec_ops  (dec_ops),
        .sw_excp  (sw_excp),
        .pc       (pc),
        .plv      (plv),
        .ctrl     (fin_ctrl),
        .ops      (fin_ops),
        .excp     (fin_excp)
    );

    id_stage_reg i_id_stage_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .d_ctrl    (fin_ctrl),
        .d_ops     (fin_ops),
        .d_excp    (fin_excp),
        .out_valid (out_valid),
        .ctrl      (ctrl),
        .ops       (ops),
        .excp      (excp)
    );

endmodule

/* hw/id_stage_reg.sv */
`timescale 1ns/100ps

module id_stage_reg (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  la_decode_pkg::decode_ctrl_t d_ctrl,
    input  la_decode_pkg::operands_t    d_ops,
    input  la_decode_pkg::excp_t        d_excp,
    output logic                        out_valid,
    output la_decode_pkg::decode_ctrl_t ctrl,
    output la_decode_pkg::operands_t    ops,
    output la_decode_pkg::excp_t        excp
);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_valid <= 1'b0;
            ctrl      <= '0;
            ops       <= '0;
            excp      <= '0;
        end
        else
        begin
            out_valid <= in_valid;
            ctrl      <= in_valid ? d_ctrl : '0;   // Bubble reads as all zero
            ops       <= in_valid ? d_ops  : '0;
            excp      <= in_valid ? d_excp : '0;
        end
    end

endmodule

/* id_stage.f */
+incdir+tests
common/la_decode_pkg.sv
hw/decoder/opcode_decode.sv
hw/decoder/operand_extract.sv
hw/decoder/excp_resolve.sv
hw/id_stage_reg.sv
hw/id_stage.sv
tests/id_stage_sva.sv
tests/id_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module id_stage_tb -f id_stage.f -o id_stage_sim
./obj_dir/id_stage_sim | tee sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi
echo "Simulation finished without a reported failure"

/* tests/id_stage_sva.sv */
`timescale 1ns/100ps

module id_stage_sva (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        out_valid,
    input la_decode_pkg::decode_ctrl_t ctrl,
    input la_decode_pkg::operands_t    ops,
    input la_decode_pkg::excp_t        excp
);

    bubble_is_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> (ctrl == '0 && ops == '0 && excp == '0))
        else $error("Bundles are not zero while out_valid is low");

    mem_dir_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(ctrl.mem_read && ctrl.mem_write))
        else $error("mem_read and mem_write are set together");

    excp_is_inert: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.unit == la_decode_pkg::UNIT_EXCP |->
            !(ctrl.reg_write || ctrl.mem_read || ctrl.mem_write || ctrl.pc_branch))
        else $error("Exception class carries side-effect enables");

endmodule

/* tests/id_model.svh */
`ifndef ID_MODEL_SVH
`define ID_MODEL_SVH

typedef struct packed {
    logic                        valid;
    la_decode_pkg::decode_ctrl_t ctrl;
    la_decode_pkg::operands_t    ops;
    la_decode_pkg::excp_t        excp;
} stage_result_t;

// Kind numbers index the opcode table, grouped by instruction format
localparam int K_SYSCALL   = 11;
localparam int K_BREAK     = 12;
localparam int K_SLLI_W    = 13;
localparam int K_SLTI      = 16;
localparam int K_ANDI      = 19;
localparam int K_LD_B      = 22;
localparam int K_ST_B      = 25;
localparam int K_LD_BU     = 28;
localparam int K_LU12I_W   = 30;
localparam int K_PCADDU12I = 31;
localparam int K_JIRL      = 32;
localparam int K_B         = 33;
localparam int K_BL        = 34;
localparam int K_BEQ       = 35;
localparam int NUM_KINDS   = 41;

localparam logic [16:0] KIND_OP [0:NUM_KINDS-1] = '{
    17'h00020, 17'h00022, 17'h00024, 17'h00025, 17'h00028, 17'h00029, 17'h0002a, 17'h0002b,
    17'h0002e, 17'h0002f, 17'h00030, 17'h00056, 17'h00054, 17'h00081, 17'h00089, 17'h00091,
    17'h00008, 17'h00009, 17'h0000a, 17'h0000d, 17'h0000e, 17'h0000f,
    17'h000a0, 17'h000a1, 17'h000a2, 17'h000a4, 17'h000a5, 17'h000a6, 17'h000a8, 17'h000a9,
    17'h0000a, 17'h0000e,
    17'h00013, 17'h00014, 17'h00015, 17'h00016, 17'h00017, 17'h00018, 17'h00019, 17'h0001a,
    17'h0001b
};

// Low bit of the opcode field for each format
function automatic int kind_shift(input int k);
    if (k < K_SLTI)
        return 15;                                  // 3R, ui5, SYSCALL, BREAK
    if (k < K_LU12I_W)
        return 22;                                  // si12 and memory
    if (k < K_JIRL)
        return 25;
    return 26;
endfunction

function automatic int find_kind(input logic [31:0] word);
    for (int k = 0; k < NUM_KINDS; k++)
        if ((word >> kind_shift(k)) == {15'd0, KIND_OP[k]})
            return k;
    return -1;                                      // Not a kept instruction
endfunction

function automatic logic [31:0] kept_word(input int k, input logic [31:0] fields);
    logic [31:0] low_mask;
    low_mask = (32'd1 << kind_shift(k)) - 32'd1;
    return ({15'd0, KIND_OP[k]} << kind_shift(k)) | (fields & low_mask);
endfunction

function automatic logic [31:0] dropped_word(input int sel, input logic [31:0] fields);
    case (sel)
        0: return {17'h00038, fields[14:0]};                     // MUL.W
        1: return {17'h00040, fields[14:0]};                     // DIV.W
        2: return {8'h04, fields[23:10], 5'd0, fields[4:0]};     // CSRRD
        3: return {8'h20, fields[23:0]};                         // LL.W
        4: return {17'h070e4, fields[14:0]};                     // DBAR
        5: return {17'h070e5, fields[14:0]};                     // IBAR
        6: return {10'h0ab, fields[21:0]};                       // PRELD
        default: return 32'h0648_3800;                           // ERTN
    endcase
endfunction

function automatic la_decode_pkg::alu_op_e kind_alu_op(input int k);
    case (k)
        0, 18, 31, 32, 34: return la_decode_pkg::ALU_ADD;
        1, 35, 36:         return la_decode_pkg::ALU_SUB;
        2, 16, 37, 38:     return la_decode_pkg::ALU_SLT;
        3, 17, 39, 40:     return la_decode_pkg::ALU_SLTU;
        4:                 return la_decode_pkg::ALU_NOR;
        6, 20:             return la_decode_pkg::ALU_OR;
        7, 21:             return la_decode_pkg::ALU_XOR;
        8, 13:             return la_decode_pkg::ALU_SLL;
        9, 14:             return la_decode_pkg::ALU_SRL;
        10, 15:            return la_decode_pkg::ALU_SRA;
        30:                return la_decode_pkg::ALU_PASS_B;
        default:           return la_decode_pkg::ALU_AND;    // AND, ANDI, B, memory, EXCP
    endcase
endfunction

function automatic stage_result_t predict(input logic valid, input logic [31:0] ir,
                                          input logic [31:0] pc, input logic [1:0] plv);
    stage_result_t r;
    int            k;
    logic          load;
    r = '0;
    if (!valid)
        return r;                                   // Bubble reads all zero
    r.valid = 1'b1;
    k = find_kind(ir);
    if (k < 0 || k == K_SYSCALL || k == K_BREAK)
    begin
        r.ctrl.unit  = la_decode_pkg::UNIT_EXCP;
        r.excp.ecode = (k == K_SYSCALL) ? la_decode_pkg::ECODE_SYS :
                       (k == K_BREAK) ? la_decode_pkg::ECODE_BRK : la_decode_pkg::ECODE_INE;
    end
    else if (k >= K_LD_B && k < K_LU12I_W)
    begin
        load               = !(k >= K_ST_B && k < K_LD_BU);
        r.ctrl.unit        = la_decode_pkg::UNIT_MEM;
        r.ctrl.sub_op      = 3'(k - K_LD_B);        // Table order matches size codes
        r.ctrl.reg_write   = load;
        r.ctrl.mem_read    = load;
        r.ctrl.mem_write   = !load;
    end
    else if (k == K_JIRL || k == K_BL)
    begin
        r.ctrl.unit      = la_decode_pkg::UNIT_LINK;
        r.ctrl.alu_op    = kind_alu_op(k);
        r.ctrl.sub_op    = (k == K_BL) ? 3'd1 : 3'd0;
        r.ctrl.reg_write = 1'b1;
        r.ctrl.pc_branch = 1'b1;
        r.ctrl.src1_pc   = 1'b1;
        r.ctrl.src2      = la_decode_pkg::SRC2_FOUR;
    end
    else if (k >= K_JIRL)
    begin
        r.ctrl.unit      = la_decode_pkg::UNIT_BRANCH;
        r.ctrl.alu_op    = kind_alu_op(k);
        r.ctrl.sub_op    = (k == K_B) ? 3'd0 : 3'(k - K_BEQ + 1);
        r.ctrl.pc_branch = 1'b1;
        r.ctrl.src2      = la_decode_pkg::SRC2_CMP_REG;
    end
    else
    begin
        r.ctrl.unit      = la_decode_pkg::UNIT_ALU;
        r.ctrl.alu_op    = kind_alu_op(k);
        r.ctrl.reg_write = 1'b1;
        r.ctrl.src1_pc   = (k == K_PCADDU12I);
        r.ctrl.src2      = (k < K_SYSCALL) ? la_decode_pkg::SRC2_REG : la_decode_pkg::SRC2_IMM;
    end

    if (k >= 0 && k < K_SYSCALL)
    begin
        r.ops.rk = ir[14:10];
        r.ops.rj = ir[9:5];
        r.ops.rd = ir[4:0];
    end
    else if (k >= K_SLLI_W && k < K_LU12I_W)
    begin
        r.ops.rj = ir[9:5];
        r.ops.rd = ir[4:0];
        if (k < K_SLTI)
            r.ops.imm = {27'd0, ir[14:10]};
        else if (k >= K_ANDI && k < K_LD_B)
            r.ops.imm = {20'd0, ir[21:10]};         // Logic immediates zero-extend
        else
            r.ops.imm = {{20{ir[21]}}, ir[21:10]};
    end
    else if (k == K_LU12I_W || k == K_PCADDU12I)
    begin
        r.ops.rd  = ir[4:0];
        r.ops.imm = {ir[24:5], 12'd0};
    end
    else if (k == K_B || k == K_BL)
    begin
        r.ops.rd  = (k == K_BL) ? 5'd1 : 5'd0;
        r.ops.imm = {{4{ir[9]}}, ir[9:0], ir[25:10], 2'b00};
    end
    else if (k >= K_JIRL)
    begin
        r.ops.rj  = ir[9:5];
        r.ops.rd  = ir[4:0];
        r.ops.imm = {{14{ir[25]}}, ir[25:10], 2'b00};
    end

    if (pc[1:0] != 2'b00 || (pc[31] && plv != 2'b00))
    begin
        r.ctrl       = '0;
        r.ctrl.unit  = la_decode_pkg::UNIT_EXCP;
        r.ops        = '0;
        r.excp.ecode = la_decode_pkg::ECODE_ADE;
        r.excp.esub  = (pc[1:0] == 2'b00) ? la_decode_pkg::ESUB_ADEM : 1'b0;  // ADEF first
    end
    return r;
endfunction

`endif

/* tests/id_stage_tb.sv */
`timescale 1ns/100ps

module id_stage_tb;

    localparam int NUM_CYCLES   = 2000;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int WATCHDOG_NS  = (NUM_CYCLES + 20) * CLK_PERIOD * 2;

    `include "id_model.svh"

    logic                        clk = 1'b0;
    logic                        rst_n;
    logic                        in_valid;
    la_decode_pkg::inst_u        ir;
    logic [31:0]                 pc;
    logic [1:0]                  plv;
    logic                        out_valid;
    la_decode_pkg::decode_ctrl_t ctrl;
    la_decode_pkg::operands_t    ops;
    la_decode_pkg::excp_t        excp;

    logic [31:0]   rng_state;
    stage_result_t pending;                         // Expectation for the next check
    string         pending_name;
    int            checks;
    int            valid_errors;
    int            ctrl_errors;
    int            ops_errors;
    int            excp_errors;

    id_stage i_id_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .ir        (ir),
        .pc        (pc),
        .plv       (plv),
        .out_valid (out_valid),
        .ctrl      (ctrl),
        .ops       (ops),
        .excp      (excp)
    );

    bind id_stage_reg id_stage_sva i_id_stage_sva (
        .clk       (clk),
        .rst_n     (rst_n),
        .out_valid (out_valid),
        .ctrl      (ctrl),
        .ops       (ops),
        .excp      (excp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw_random(output logic [31:0] value);
        rng_state = xorshift32(rng_state);
        value     = rng_state;
    endtask

    function automatic string behavior_name(input stage_result_t r);
        if (!r.valid)
            return "valid_timing";
        if (r.excp.ecode == la_decode_pkg::ECODE_ADE)
            return "addr_exception";
        case (r.ctrl.unit)
            la_decode_pkg::UNIT_MEM:  return "memory";
            la_decode_pkg::UNIT_BRANCH,
            la_decode_pkg::UNIT_LINK: return "control_transfer";
            la_decode_pkg::UNIT_EXCP: return "sw_exception";
            default:                  return "alu";
        endcase
    endfunction

    task automatic drive_stimulus();
        logic [31:0] sel;
        logic [31:0] fields;
        logic [31:0] addr;
        logic [31:0] misc;
        logic [31:0] word;
        draw_random(sel);
        draw_random(fields);
        draw_random(addr);
        draw_random(misc);
        if (sel[2:0] == 3'd7)
            word = fields;                          // Fully random word
        else if (sel[2:0] == 3'd6)
            word = dropped_word(int'(sel[10:8]), fields);
        else
            word = kept_word(int'(sel[31:8] % 24'd41), fields);
        if (misc[2:0] != 3'd0)
            addr[1:0] = 2'b00;                      // Mostly word aligned
        in_valid     = (misc[5:3] != 3'd0);
        ir           = word;
        pc           = addr;
        plv          = misc[7:6];
        pending      = predict(in_valid, word, addr, misc[7:6]);
        pending_name = behavior_name(pending);
    endtask

    task automatic compare_outputs();
        checks++;
        assert (out_valid === pending.valid)
        else
        begin
            valid_errors++;
            $display("Error: %s out_valid expected %0b actual %0b",
                     pending_name, pending.valid, out_valid);
        end
        assert (ctrl === pending.ctrl)
        else
        begin
            ctrl_errors++;
            $display("Error: %s ctrl expected %h actual %h", pending_name, pending.ctrl, ctrl);
        end
        assert (ops === pending.ops)
        else
        begin
            ops_errors++;
            $display("Error: %s ops expected %h actual %h", pending_name, pending.ops, ops);
        end
        assert (excp === pending.excp)
        else
        begin
            excp_errors++;
            $display("Error: %s excp expected %h actual %h", pending_name, pending.excp, excp);
        end
    endtask

    initial
    begin
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        ir           = '0;
        pc           = '0;
        plv          = '0;
        rng_state    = 32'h7cfa_b258;
        pending      = '0;
        pending_name = "after_reset";
        checks       = 0;
        valid_errors = 0;
        ctrl_errors  = 0;
        ops_errors   = 0;
        excp_errors  = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < NUM_CYCLES; i++)
        begin
            compare_outputs();                      // Result of the previous edge
            drive_stimulus();
            @(negedge clk);
        end
        compare_outputs();
        $display("Checks %0d, errors: valid %0d, ctrl %0d, ops %0d, excp %0d",
                 checks, valid_errors, ctrl_errors, ops_errors, excp_errors);
        if (valid_errors + ctrl_errors + ops_errors + excp_errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the test sequence finished");
        $display("*** FAILED ***");
        $finish;
    end

endmodule
